/* source/nn_pkg.sv */
package nn_pkg;

    // network shape
    localparam int NUM_NEURON  = 6;
    localparam int LAYER_MAX   = 4;
    localparam int LAYER_W     = 2;   // layer index width

    // fixed point formats
    localparam int INPUT_SIZE  = 9;   // signed activation
    localparam int WEIGHT_SIZE = 17;  // signed weight, FRAC_BITS fraction
    localparam int FRAC_BITS   = 8;
    localparam int ACC_SIZE    = 30;  // six full products plus guard bits
    localparam int ACT_MAX     = 2 ** (INPUT_SIZE - 1) - 1;

    localparam int CNT_W = $clog2(NUM_NEURON);
    localparam int VEC_W = NUM_NEURON * INPUT_SIZE;
    localparam int ROW_W = NUM_NEURON * WEIGHT_SIZE;  // one neuron's weights
    localparam int MAT_W = NUM_NEURON * ROW_W;

    localparam string WEIGHTS_INIT = "source/weights.hex";

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_START,
        ST_WAIT,
        ST_ACK
    } seq_state_t;

    // element idx of an activation vector
    function automatic logic signed [INPUT_SIZE-1:0] act_at(input logic [VEC_W-1:0] vec,
                                                            input int idx);
        return vec[idx*INPUT_SIZE +: INPUT_SIZE];
    endfunction

    // column idx of one weight row
    function automatic logic signed [WEIGHT_SIZE-1:0] wgt_at(input logic [ROW_W-1:0] row,
                                                             input int idx);
        return row[idx*WEIGHT_SIZE +: WEIGHT_SIZE];
    endfunction

    // drop the weight fraction, arithmetic shift
    function automatic logic signed [ACC_SIZE-1:0] scale_acc(input logic signed [ACC_SIZE-1:0] acc);
        return acc >>> FRAC_BITS;
    endfunction

    // ReLU, then clamp to the largest positive activation
    function automatic logic [INPUT_SIZE-1:0] relu_sat(input logic signed [ACC_SIZE-1:0] val);
        if (val < 0)
            return '0;
        else if (val > ACC_SIZE'(ACT_MAX))
            return INPUT_SIZE'(ACT_MAX);
        else
            return val[INPUT_SIZE-1:0];
    endfunction

endpackage

/* source/layer_if.sv */
`timescale 1ns/100ps

interface layer_if;
    import nn_pkg::*;

    logic               start;      // one cycle pulse from the sequencer
    logic [LAYER_W-1:0] layer_num;
    logic [VEC_W-1:0]   inputs;     // held from start until valid
    logic [MAT_W-1:0]   weights;
    logic [VEC_W-1:0]   outputs;
    logic               valid;      // one cycle pulse, outputs good with it

    // sequencer side
    modport seq (
        output start, layer_num, inputs, weights,
        input  outputs, valid
    );

    // layer side
    modport lay (
        input  start, layer_num, inputs, weights,
        output outputs, valid
    );

endinterface

/* source/weight_rom.sv */
`timescale 1ns/100ps

module weight_rom (
    input  logic                       clk,
    input  logic                       rd_en,
    input  logic [nn_pkg::LAYER_W-1:0] addr,
    output logic [nn_pkg::MAT_W-1:0]   data
);
    import nn_pkg::*;

    // one full matrix per layer pass
    logic [MAT_W-1:0] mem [LAYER_MAX];

    initial begin
        $readmemh(WEIGHTS_INIT, mem);
    end

    // one cycle read latency, data holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            data <= mem[addr];
        end
    end

endmodule

/* source/neuron.sv */
`timescale 1ns/100ps

module neuron (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic [nn_pkg::VEC_W-1:0]      inputs,
    input  logic [nn_pkg::ROW_W-1:0]      weight_row,
    output logic [nn_pkg::INPUT_SIZE-1:0] result,
    output logic                          done
);
    import nn_pkg::*;

    logic                       busy;     // accumulating
    logic [CNT_W-1:0]           cnt;      // input index
    logic signed [ACC_SIZE-1:0] acc;
    logic signed [ACC_SIZE-1:0] product;

    // signed operands, extended to accumulator width before the multiply
    assign product = act_at(inputs, cnt) * wgt_at(weight_row, cnt);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                if (cnt == CNT_W'(NUM_NEURON - 1)) begin
                    busy <= 1'b0;
                    cnt  <= '0;
                    done <= 1'b1;   // last product in
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // one product per cycle
    always_ff @(posedge clk) begin
        if (start) begin
            acc <= '0;
        end else if (busy) begin
            acc <= acc + product;
        end
    end

    // done marks the cycle the result register loads
    always_ff @(posedge clk) begin
        if (done) begin
            result <= relu_sat(scale_acc(acc));
        end
    end

endmodule

/* source/neural_layer.sv */
`timescale 1ns/100ps

module neural_layer (
    input logic  clk,
    input logic  rst,
    layer_if.lay lyr
);
    import nn_pkg::*;

    logic [NUM_NEURON-1:0] done;

    // neuron i takes row i of the matrix, writes slice i of the vector
    for (genvar i = 0; i < NUM_NEURON; i++) begin : g_neuron
        neuron i_neuron (
            .clk        (clk),
            .rst        (rst),
            .start      (lyr.start),
            .inputs     (lyr.inputs),
            .weight_row (lyr.weights[i*ROW_W +: ROW_W]),
            .result     (lyr.outputs[i*INPUT_SIZE +: INPUT_SIZE]),
            .done       (done[i])
        );
    end

    // all neurons share start so they finish together
    // valid lands once every result register has loaded
    always_ff @(posedge clk) begin
        if (rst) begin
            lyr.valid <= 1'b0;
        end else begin
            lyr.valid <= &done;
        end
    end

endmodule

/* source/input_aggregator.sv */
`timescale 1ns/100ps

module input_aggregator (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req,
    input  logic [nn_pkg::VEC_W-1:0]   in_vec,
    output logic                       ack,
    output logic [nn_pkg::VEC_W-1:0]   out_vec,
    output logic                       layer_busy,
    output logic                       rom_rd,
    output logic [nn_pkg::LAYER_W-1:0] rom_addr,
    input  logic [nn_pkg::MAT_W-1:0]   rom_data,
    layer_if.seq                       lyr
);
    import nn_pkg::*;

    seq_state_t         state;
    logic [VEC_W-1:0]   act_buf;    // current layer input
    logic [MAT_W-1:0]   wgt_buf;    // current layer weights
    logic [LAYER_W-1:0] layer_idx;
    logic               last_layer;
    logic               accept;     // new request taken this cycle
    logic               fb_valid;   // layer result back this cycle

    assign last_layer = (layer_idx == LAYER_W'(LAYER_MAX - 1));
    assign accept     = (state == ST_IDLE) && req;
    assign fb_valid   = (state == ST_WAIT) && lyr.valid;

    // rom address goes out one cycle ahead of ST_LOAD
    assign rom_rd   = accept || (fb_valid && !last_layer);
    assign rom_addr = (state == ST_IDLE) ? '0 : layer_idx + 1'b1;

    assign lyr.start     = (state == ST_START);
    assign lyr.layer_num = layer_idx;
    assign lyr.inputs    = act_buf;
    assign lyr.weights   = wgt_buf;

    assign layer_busy = (state == ST_LOAD) || (state == ST_START) || (state == ST_WAIT);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            layer_idx <= '0;
            ack       <= 1'b0;
            out_vec   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        layer_idx <= '0;
                        state     <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    state <= ST_START;  // rom_data is valid here
                end
                ST_START: begin
                    state <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (lyr.valid) begin
                        if (last_layer) begin
                            out_vec <= lyr.outputs;
                            ack     <= 1'b1;
                            state   <= ST_ACK;
                        end else begin
                            layer_idx <= layer_idx + 1'b1;
                            state     <= ST_LOAD;
                        end
                    end
                end
                ST_ACK: begin
                    // hold ack and out_vec until the host lets go
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // outside vector first, then each layer feeds the next
    always_ff @(posedge clk) begin
        if (accept) begin
            act_buf <= in_vec;
        end else if (fb_valid) begin
            act_buf <= lyr.outputs;
        end
        if (state == ST_LOAD) begin
            wgt_buf <= rom_data;
        end
    end

endmodule

/* source/nn_core_top.sv */
`timescale 1ns/100ps

module nn_core_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req,
    input  logic [nn_pkg::VEC_W-1:0] in_vec,
    output logic                     ack,
    output logic [nn_pkg::VEC_W-1:0] out_vec,
    output logic                     layer_busy
);
    import nn_pkg::*;

    logic               rom_rd;
    logic [LAYER_W-1:0] rom_addr;
    logic [MAT_W-1:0]   rom_data;

    layer_if lyr ();    // sequencer to layer

    weight_rom i_rom (
        .clk   (clk),
        .rd_en (rom_rd),
        .addr  (rom_addr),
        .data  (rom_data)
    );

    input_aggregator i_seq (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .in_vec     (in_vec),
        .ack        (ack),
        .out_vec    (out_vec),
        .layer_busy (layer_busy),
        .rom_rd     (rom_rd),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .lyr        (lyr.seq)
    );

    // single layer instance, reused for every pass
    neural_layer i_layer (
        .clk (clk),
        .rst (rst),
        .lyr (lyr.lay)
    );

endmodule

/* dv/nn_core_checker.sv */
`timescale 1ns/100ps

module nn_core_checker (
    input logic                     clk,
    input logic                     rst,
    input logic                     req,
    input logic                     ack,
    input logic [nn_pkg::VEC_W-1:0] out_vec,
    input logic                     start,
    input logic                     valid
);
    logic pending;  // layer started, valid not seen yet

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (start) begin
            pending <= 1'b1;
        end else if (valid) begin
            pending <= 1'b0;
        end
    end

    // host side four phase handshake
    // ack is set on the edge after the cycle that saw req
    ack_rise_with_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    ack_fall_after_req: assert property (@(posedge clk) disable iff (rst)
        $fell(ack) |-> !$past(req))
        else $error("ack dropped before req was released");

    out_held_with_ack: assert property (@(posedge clk) disable iff (rst)
        (ack && $past(ack)) |-> $stable(out_vec))
        else $error("out_vec changed while ack was high");

    // sequencer to layer pulses
    start_after_valid: assert property (@(posedge clk) disable iff (rst)
        start |-> !pending)
        else $error("layer started again before its valid");

    valid_after_start: assert property (@(posedge clk) disable iff (rst)
        valid |-> pending)
        else $error("layer valid without a start");

    no_start_in_ack: assert property (@(posedge clk) disable iff (rst)
        ack |-> !start)
        else $error("layer started while ack was high");

endmodule

/* dv/nn_core_tb.sv */
`timescale 1ns/100ps

module nn_core_tb;
    import nn_pkg::*;

    localparam logic [31:0] SEED  = 32'h90c7_1ec5;
    localparam int RST_CYCLES     = 10;
    localparam int MAX_REQS       = 20;
    localparam int REQ_CYCLES     = 60;     // latency, ack hold and gap
    localparam int CYCLE_LIMIT    = RST_CYCLES + MAX_REQS * REQ_CYCLES;
    localparam int NUM_RANDOM     = 12;

    logic             clk;
    logic             rst;
    logic             req;
    logic [VEC_W-1:0] in_vec;
    logic             ack;
    logic [VEC_W-1:0] out_vec;
    logic             layer_busy;

    logic [MAT_W-1:0] ref_mem [LAYER_MAX];  // model copy of the weights
    int               cycles = 0;
    bit               passed = 1'b0;
    bit               fail_shown = 1'b0;

    nn_core_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .in_vec     (in_vec),
        .ack        (ack),
        .out_vec    (out_vec),
        .layer_busy (layer_busy)
    );

    bind nn_core_top nn_core_checker i_checker (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .ack     (ack),
        .out_vec (out_vec),
        .start   (lyr.start),
        .valid   (lyr.valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic void report_fail();
        if (!fail_shown) begin
            fail_shown = 1'b1;
            $display("** FAIL **");
        end
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        report_fail();
        $fatal(1, "simulation stopped on error");
    endtask

    final begin
        if (!passed) begin
            report_fail();
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            abort_run("timeout: the core did not finish within the cycle limit");
        end
    end

    task automatic step();
        @(posedge clk);
        #10;
    endtask

    // dot product, drop the fraction, then ReLU and clamp
    function automatic logic [VEC_W-1:0] ref_layer(input logic [VEC_W-1:0] x,
                                                   input logic [MAT_W-1:0] m);
        logic [VEC_W-1:0]              y;
        logic signed [ACC_SIZE-1:0]    sum;
        logic signed [INPUT_SIZE-1:0]  a;
        logic signed [WEIGHT_SIZE-1:0] w;
        y = '0;
        for (int i = 0; i < NUM_NEURON; i++) begin
            sum = '0;
            for (int j = 0; j < NUM_NEURON; j++) begin
                a   = x[j*INPUT_SIZE +: INPUT_SIZE];
                w   = m[(i*NUM_NEURON + j)*WEIGHT_SIZE +: WEIGHT_SIZE];
                sum = sum + ACC_SIZE'(a) * ACC_SIZE'(w);
            end
            y[i*INPUT_SIZE +: INPUT_SIZE] = relu_sat(sum >>> FRAC_BITS);
        end
        return y;
    endfunction

    function automatic logic [VEC_W-1:0] ref_infer(input logic [VEC_W-1:0] x);
        logic [VEC_W-1:0] v;
        v = x;
        for (int l = 0; l < LAYER_MAX; l++) begin
            v = ref_layer(v, ref_mem[l]);
        end
        return v;
    endfunction

    function automatic logic [VEC_W-1:0] random_vec(input int max_val);
        logic [VEC_W-1:0] v;
        for (int i = 0; i < NUM_NEURON; i++) begin
            v[i*INPUT_SIZE +: INPUT_SIZE] = INPUT_SIZE'($urandom_range(max_val, 0));
        end
        return v;
    endfunction

    // even slices get one value, odd slices the other
    function automatic logic [VEC_W-1:0] fill_vec(input logic [INPUT_SIZE-1:0] even_val,
                                                  input logic [INPUT_SIZE-1:0] odd_val);
        logic [VEC_W-1:0] v;
        for (int i = 0; i < NUM_NEURON; i++) begin
            v[i*INPUT_SIZE +: INPUT_SIZE] = (i % 2 == 0) ? even_val : odd_val;
        end
        return v;
    endfunction

    // one full four phase transfer, random ack hold and idle gap
    task automatic run_request(input string name, input logic [VEC_W-1:0] vec);
        logic [VEC_W-1:0] expected;
        int               hold;
        int               gap;
        expected = ref_infer(vec);
        hold     = $urandom_range(20, 0);
        gap      = $urandom_range(5, 0);
        in_vec   = vec;
        req      = 1'b1;
        step();
        while (!ack) begin
            assert (layer_busy)
            else abort_run("layer_busy was low while a request was in flight");
            step();
        end
        assert (out_vec == expected)
        else abort_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, out_vec));
        repeat (hold) begin
            step();
            assert (!layer_busy)
            else abort_run("layer_busy went high while the result was held");
        end
        req = 1'b0;
        step();
        while (ack) begin
            step();
        end
        in_vec = random_vec(ACT_MAX);   // junk, must not leak into the next run
        repeat (gap) begin
            step();
        end
    endtask

    initial begin
        void'($urandom(SEED));
        $readmemh(WEIGHTS_INIT, ref_mem);
        rst    = 1'b1;
        req    = 1'b0;
        in_vec = '0;
        repeat (RST_CYCLES) begin
            step();
        end
        rst = 1'b0;

        // idle outputs stay quiet while in_vec moves
        repeat (4) begin
            in_vec = random_vec(ACT_MAX);
            step();
            assert (!ack && !layer_busy && out_vec == '0)
            else abort_run("outputs not idle after reset");
        end

        run_request("zero_input", '0);
        for (int n = 0; n < NUM_RANDOM; n++) begin
            run_request($sformatf("random_%0d", n), random_vec(ACT_MAX >> (n % 8)));
        end
        run_request("sat_high", fill_vec(INPUT_SIZE'(ACT_MAX), INPUT_SIZE'(ACT_MAX)));
        run_request("relu_low", fill_vec(9'h100, 9'h100));     // most negative input
        run_request("mixed_even_high", fill_vec(INPUT_SIZE'(ACT_MAX), 9'h100));
        run_request("mixed_odd_high", fill_vec(9'h100, INPUT_SIZE'(ACT_MAX)));

        passed = 1'b1;
        $display("** PASS **");
        $finish;
    end

endmodule

/* source/weights.hex */
// one layer matrix per line, 36 signed 17-bit weights with 8 fraction bits
// weight of row i (neuron) and column j (input) sits at bit (i*6+j)*17
00207FF000100010000207FF000100010000207FF000100010000207FF000100010000207FF000100010000207FF000100010000207FF000100010000207FF000100010000207FF0001000100
008000203FF0000C0008000203FF0000C0008000203FF0000C0008000203FF0000C0008000203FF0000C0008000203FF0000C0008000203FF0000C0008000203FF0000C0008000203FF0000C0
0060001000201FFC00060001000201FFC00060001000201FFC00060001000201FFC00060001000201FFC00060001000201FFC00060001000201FFC00060001000201FFC00060001000201FFC0
FFC00040000800080FFC00040000800080FFC00040000800080FFC00040000800080FFC00040000800080FFC00040000800080FFC00040000800080FFC00040000800080FFC00040000800080

/* src.f */
source/nn_pkg.sv
source/layer_if.sv
source/weight_rom.sv
source/neuron.sv
source/neural_layer.sv
source/input_aggregator.sv
source/nn_core_top.sv
dv/nn_core_checker.sv
dv/nn_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module nn_core_tb -f src.f -o nn_core_sim

output=$(./obj_dir/nn_core_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qxF '** PASS **'; then
    exit 0
fi
exit 1
